/* sim.f */
+incdir+hw
hw/rix_pkg.sv
hw/fb_regs.sv
hw/fb_writer.sv
hw/cmd_dma.sv
hw/mem_arbiter.sv
hw/rix_top.sv
testbench/tb_rix_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rasterizer memory shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_rix_top -o sim_rix
./obj_dir/sim_rix | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* testbench/tb_rix_top.sv */
// **************************************************************************
// Rasterizer memory shell testbench
// Directed tests for the APB registers, command DMA, frame commit,
// write arbitration and memory back-pressure
// **************************************************************************
`include "rix_consts.svh"

module tb_rix_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                   aclk;
    logic                   rst_n;
    rix_pkg::apb_req_t      apb_req;
    rix_pkg::apb_rsp_t      apb_rsp;
    rix_pkg::stream_beat_t  cmd_in;
    logic                   cmd_valid;
    logic                   cmd_ready;
    rix_pkg::stream_beat_t  pix_in;
    logic                   pix_valid;
    logic                   pix_ready;
    rix_pkg::mem_wr_t       mem_wr;
    logic                   mem_valid;
    logic                   mem_ready = 1'b1;
    logic                   swap_fb;
    logic                   swap_fb_enable_vsync;
    logic                   irq;

    // The memory model and the event counters sample the DUT on the falling edge
    logic [31:0]            mem [logic [31:0]];
    int                     wr_count = 0;
    int                     swap_count = 0;
    logic                   swap_vsync = 1'b0;
    bit                     rand_ready = 1'b0;
    int                     cycles = 0;

    rix_top i_dut (
        .aclk                 (aclk),
        .rst_n                (rst_n),
        .apb_req              (apb_req),
        .apb_rsp              (apb_rsp),
        .cmd_in               (cmd_in),
        .cmd_valid            (cmd_valid),
        .cmd_ready            (cmd_ready),
        .pix_in               (pix_in),
        .pix_valid            (pix_valid),
        .pix_ready            (pix_ready),
        .mem_wr               (mem_wr),
        .mem_valid            (mem_valid),
        .mem_ready            (mem_ready),
        .swap_fb              (swap_fb),
        .swap_fb_enable_vsync (swap_fb_enable_vsync),
        .irq                  (irq)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    always @(posedge aclk)
    begin
        #10;
        mem_ready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    always @(negedge aclk)
    begin
        if (mem_valid && mem_ready)
        begin
            mem[mem_wr.addr] = mem_wr.data;
            wr_count++;
        end
        if (swap_fb)
        begin
            swap_count++;
            swap_vsync = swap_fb_enable_vsync;
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return 'x;
    endfunction

    // Advance to the drive point just after the next rising edge
    task automatic step();
        @(posedge aclk);
        #10;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        step();
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        step();
        apb_req.penable = 1'b1;
        @(negedge aclk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_eq(32'(apb_rsp.pready), 32'd1, "pready in the access cycle");
        step();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic push_cmd(input logic [31:0] data, input logic last, input bit gaps);
        logic taken;
        if (gaps)
            repeat ($urandom_range(0, 2)) step();
        cmd_in.data = data;
        cmd_in.last = last;
        cmd_valid   = 1'b1;
        do
        begin
            @(negedge aclk);
            taken = cmd_ready;
            step();
        end while (!taken);
        cmd_valid = 1'b0;
    endtask

    task automatic push_pix(input logic [31:0] data, input logic last, input bit gaps);
        logic taken;
        if (gaps)
            repeat ($urandom_range(0, 2)) step();
        pix_in.data = data;
        pix_in.last = last;
        pix_valid   = 1'b1;
        do
        begin
            @(negedge aclk);
            taken = pix_ready;
            step();
        end while (!taken);
        pix_valid = 1'b0;
    endtask

    task automatic send_cmd_packet(input logic [31:0] addr, input logic [31:0] words[$],
                                   input bit gaps);
        push_cmd(addr, words.size() == 0, gaps);
        for (int i = 0; i < words.size(); i++)
            push_cmd(words[i], i == words.size() - 1, gaps);
    endtask

    task automatic send_pixels(input logic [31:0] words[$], input bit gaps);
        for (int i = 0; i < words.size(); i++)
            push_pix(words[i], i == words.size() - 1, gaps);
    endtask

    task automatic check_range(input logic [31:0] base, input logic [31:0] words[$],
                               input string what);
        for (int i = 0; i < words.size(); i++)
            check_eq(mem_word(base + 32'(i) * `RIX_WORD_BYTES), words[i],
                     $sformatf("%s word %0d", what, i));
    endtask

    task automatic test_reset_regs();
        logic [31:0] rdata;
        logic        err;
        check_eq(32'(mem_valid), 32'd0, "mem_valid after reset");
        check_eq(32'(swap_fb), 32'd0, "swap_fb after reset");
        check_eq(32'(irq), 32'd0, "irq after reset");
        check_eq(32'(pix_ready), 32'd0, "pix_ready with no frame committed");
        check_eq(32'(cmd_ready), 32'd1, "cmd_ready when idle after reset");
        for (int r = 0; r < 4; r++)
        begin
            apb_read(4'(r * 4), rdata, err);
            check_eq(rdata, 32'd0, $sformatf("register 0x%0h after reset", r * 4));
            check_eq(32'(err), 32'd0, "pslverr on a mapped register");
        end
        apb_write(`RIX_REG_FB_BASE, 32'h1234_5678);
        apb_read(`RIX_REG_FB_BASE, rdata, err);
        check_eq(rdata, 32'h1234_5678, "FB_BASE read back");
        // Only the low 20 bits of the size are kept
        apb_write(`RIX_REG_FB_SIZE, 32'hFFFF_FFFF);
        apb_read(`RIX_REG_FB_SIZE, rdata, err);
        check_eq(rdata, 32'h000F_FFFF, "FB_SIZE read back");
        apb_write(`RIX_REG_CTRL, 32'd1 << `RIX_CTRL_VSYNC_BIT);
        apb_read(`RIX_REG_CTRL, rdata, err);
        check_eq(rdata, 32'd1 << `RIX_CTRL_VSYNC_BIT, "CTRL vsync read back");
        apb_write(`RIX_REG_CTRL, 32'd0);
        apb_read(4'hE, rdata, err);
        check_eq(32'(err), 32'd1, "pslverr on an unmapped offset");
    endtask

    task automatic test_cmd_dma();
        logic [31:0] words[$];
        logic [31:0] none[$];
        int          start;
        for (int i = 0; i < 5; i++)
            words.push_back(32'hA5A5_0100 + 32'(i) * 32'h0001_0003);
        start = wr_count;
        send_cmd_packet(32'h0000_1000, words, 1'b0);
        while (wr_count < start + 5)
            step();
        check_range(32'h0000_1000, words, "command payload");
        start = wr_count;
        send_cmd_packet(32'h0000_2000, none, 1'b0);
        repeat (10) step();
        check_eq(32'(wr_count - start), 32'd0, "writes from a header-only packet");
        check_eq(32'(mem.exists(32'h0000_2000)), 32'd0, "header-only packet target");
    endtask

    task automatic test_frame_commit();
        logic [31:0] pix[$];
        logic [31:0] rdata;
        logic        err;
        int          swaps;
        for (int i = 0; i < 16; i++)
            pix.push_back(32'h5A00_0000 | (32'(i) << 8) | (32'hFF - 32'(i)));
        apb_write(`RIX_REG_FB_BASE, 32'h0000_8000);
        apb_write(`RIX_REG_FB_SIZE, 32'd16);
        swaps = swap_count;
        apb_write(`RIX_REG_CTRL, 32'd3);
        apb_read(`RIX_REG_STATUS, rdata, err);
        check_eq(rdata, 32'd1 << `RIX_STATUS_BUSY_BIT, "STATUS while the frame runs");
        send_pixels(pix, 1'b0);
        while (swap_count < swaps + 1)
            step();
        repeat (5) step();
        check_eq(32'(swap_count - swaps), 32'd1, "swap_fb pulses per frame");
        check_eq(32'(swap_vsync), 32'd1, "swap_fb_enable_vsync at swap");
        check_range(32'h0000_8000, pix, "frame pixel");
        apb_read(`RIX_REG_STATUS, rdata, err);
        check_eq(rdata, 32'd1 << `RIX_STATUS_DONE_BIT, "STATUS after frame");
        check_eq(32'(irq), 32'd1, "irq after frame");
        apb_write(`RIX_REG_STATUS, 32'd1 << `RIX_STATUS_DONE_BIT);
        apb_read(`RIX_REG_STATUS, rdata, err);
        check_eq(rdata, 32'd0, "STATUS after done clear");
        check_eq(32'(irq), 32'd0, "irq after done clear");
    endtask

    task automatic test_arbitration(input bit stress);
        logic [31:0] cmd_words[$];
        logic [31:0] pix[$];
        int          start;
        int          swaps;
        for (int i = 0; i < 8; i++)
            cmd_words.push_back(32'hC3D0_0000 + 32'(i) * 32'h0000_0101);
        for (int i = 0; i < 16; i++)
            pix.push_back(32'hB1E5_0000 + 32'(i) * 32'h0000_1001);
        mem.delete();
        rand_ready = stress;
        start = wr_count;
        swaps = swap_count;
        apb_write(`RIX_REG_FB_BASE, 32'h0000_A000);
        apb_write(`RIX_REG_FB_SIZE, 32'd16);
        fork
            send_cmd_packet(32'h0000_3000, cmd_words, stress);
            begin
                apb_write(`RIX_REG_CTRL, 32'd1 << `RIX_CTRL_COMMIT_BIT);
                send_pixels(pix, stress);
            end
        join
        while (wr_count < start + 24 || swap_count < swaps + 1)
            step();
        rand_ready = 1'b0;
        repeat (10) step();
        check_eq(32'(wr_count - start), 32'd24, "total memory writes");
        check_eq(32'(swap_vsync), 32'd0, "swap_fb_enable_vsync with vsync off");
        check_range(32'h0000_3000, cmd_words, "merged command payload");
        check_range(32'h0000_A000, pix, "merged frame pixel");
        apb_write(`RIX_REG_STATUS, 32'd1 << `RIX_STATUS_DONE_BIT);
    endtask

    initial
    begin
        void'($urandom(47680));
        apb_req   = '0;
        cmd_in    = '0;
        cmd_valid = 1'b0;
        pix_in    = '0;
        pix_valid = 1'b0;
        rst_n     = 1'b0;
        repeat (3) @(posedge aclk);
        #10;
        rst_n = 1'b1;
        test_reset_regs();
        test_cmd_dma();
        test_frame_commit();
        test_arbitration(1'b0);
        // Repeat the traffic with stalls on memory and on both streams
        test_arbitration(1'b1);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* hw/rix_top.sv */
// **************************************************************************
// Rasterizer memory shell top level
// Command DMA and framebuffer writer sharing one memory write port, with
// the framebuffer registers on APB
// **************************************************************************
module rix_top
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  rix_pkg::apb_req_t       apb_req,
    output rix_pkg::apb_rsp_t       apb_rsp,
    input  rix_pkg::stream_beat_t   cmd_in,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  rix_pkg::stream_beat_t   pix_in,
    input  logic                    pix_valid,
    output logic                    pix_ready,
    output rix_pkg::mem_wr_t        mem_wr,
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output logic                    swap_fb,
    output logic                    swap_fb_enable_vsync,
    output logic                    irq
);
    rix_pkg::fb_cfg_t   fb_cfg;
    logic               fb_commit;
    logic               fb_busy;
    rix_pkg::mem_wr_t   dma_wr;
    logic               dma_wr_valid;
    logic               dma_wr_ready;
    rix_pkg::mem_wr_t   fb_wr;
    logic               fb_wr_valid;
    logic               fb_wr_ready;

    fb_regs i_fb_regs (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .busy       (fb_busy),
        .frame_done (swap_fb),
        .cfg        (fb_cfg),
        .commit     (fb_commit),
        .irq        (irq)
    );

    // The frame done pulse doubles as the buffer swap request
    fb_writer i_fb_writer (
        .aclk                 (aclk),
        .rst_n                (rst_n),
        .cfg                  (fb_cfg),
        .commit               (fb_commit),
        .pix_in               (pix_in),
        .pix_valid            (pix_valid),
        .pix_ready            (pix_ready),
        .wr                   (fb_wr),
        .wr_valid             (fb_wr_valid),
        .wr_ready             (fb_wr_ready),
        .busy                 (fb_busy),
        .frame_done           (swap_fb),
        .swap_fb_enable_vsync (swap_fb_enable_vsync)
    );

    cmd_dma i_cmd_dma (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cmd_in    (cmd_in),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .wr        (dma_wr),
        .wr_valid  (dma_wr_valid),
        .wr_ready  (dma_wr_ready)
    );

    mem_arbiter i_mem_arbiter (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .req0       (dma_wr),
        .req0_valid (dma_wr_valid),
        .req0_ready (dma_wr_ready),
        .req1       (fb_wr),
        .req1_valid (fb_wr_valid),
        .req1_ready (fb_wr_ready),
        .mem_wr     (mem_wr),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready)
    );

endmodule

/* hw/mem_arbiter.sv */
// **************************************************************************
// Memory write arbiter
// Round-robin merge of two write requesters onto one memory write port.
// A stalled grant is held until its write transfers
// **************************************************************************
`include "rix_consts.svh"

module mem_arbiter
(
    input  logic                aclk,
    input  logic                rst_n,
    input  rix_pkg::mem_wr_t    req0,
    input  logic                req0_valid,
    output logic                req0_ready,
    input  rix_pkg::mem_wr_t    req1,
    input  logic                req1_valid,
    output logic                req1_ready,
    output rix_pkg::mem_wr_t    mem_wr,
    output logic                mem_valid,
    input  logic                mem_ready
);
    logic [`RIX_ARB_REQS-1:0]           req_valid;
    logic [$clog2(`RIX_ARB_REQS)-1:0]   prio;
    logic [$clog2(`RIX_ARB_REQS)-1:0]   owner_q;
    logic [$clog2(`RIX_ARB_REQS)-1:0]   pick;
    logic [$clog2(`RIX_ARB_REQS)-1:0]   sel;
    logic                               locked;

    assign req_valid = {req1_valid, req0_valid};

    // Priority side wins a tie, otherwise whoever is asking
    assign pick = (req_valid[prio]) ? prio : ~prio;
    assign sel  = locked ? owner_q : pick;

    assign mem_valid  = req_valid[sel];
    assign mem_wr     = sel ? req1 : req0;
    assign req0_ready = mem_ready && (sel == 1'b0);
    assign req1_ready = mem_ready && (sel == 1'b1);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prio    <= '0;
            owner_q <= '0;
            locked  <= 1'b0;
        end
        else if (mem_valid)
        begin
            if (mem_ready)
            begin
                locked <= 1'b0;
                prio   <= ~sel;
            end
            else
            begin
                locked  <= 1'b1;
                owner_q <= sel;
            end
        end
    end

endmodule

/* hw/cmd_dma.sv */
// **************************************************************************
// Command DMA
// Takes the byte address from the header word of each packet and writes
// the following payload words to memory at consecutive word addresses
// **************************************************************************
`include "rix_consts.svh"

module cmd_dma
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  rix_pkg::stream_beat_t   cmd_in,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    output rix_pkg::mem_wr_t        wr,
    output logic                    wr_valid,
    input  logic                    wr_ready
);
    localparam logic ST_HEADER  = 1'b0;
    localparam logic ST_PAYLOAD = 1'b1;

    logic                   state;
    logic [`RIX_ADDR_W-1:0] addr_q;
    logic                   beat_take;
    logic                   pay_take;

    // One write held at a time, so a beat is only taken when the slot frees up
    assign cmd_ready = !wr_valid || wr_ready;
    assign beat_take = cmd_ready && cmd_valid;
    assign pay_take  = beat_take && (state == ST_PAYLOAD);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_HEADER;
            wr_valid <= 1'b0;
        end
        else
        begin
            if (wr_valid && wr_ready)
                wr_valid <= 1'b0;
            if (beat_take)
            begin
                if (state == ST_HEADER)
                begin
                    // A header carrying last is an empty packet
                    if (!cmd_in.last)
                        state <= ST_PAYLOAD;
                end
                else
                begin
                    wr_valid <= 1'b1;
                    if (cmd_in.last)
                        state <= ST_HEADER;
                end
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beat_take && (state == ST_HEADER))
            addr_q <= cmd_in.data;
        if (pay_take)
        begin
            wr.addr <= addr_q;
            wr.data <= cmd_in.data;
            addr_q  <= addr_q + `RIX_WORD_BYTES;
        end
    end

endmodule

/* hw/fb_writer.sv */
// **************************************************************************
// Framebuffer writer
// On commit, writes FB_SIZE pixel words from the pixel stream to memory at
// consecutive word addresses and reports the finished frame
// **************************************************************************
`include "rix_consts.svh"

module fb_writer
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  rix_pkg::fb_cfg_t        cfg,
    input  logic                    commit,
    input  rix_pkg::stream_beat_t   pix_in,
    input  logic                    pix_valid,
    output logic                    pix_ready,
    output rix_pkg::mem_wr_t        wr,
    output logic                    wr_valid,
    input  logic                    wr_ready,
    output logic                    busy,
    output logic                    frame_done,
    output logic                    swap_fb_enable_vsync
);
    logic [`RIX_ADDR_W-1:0]     base_q;
    logic [`RIX_FB_SIZE_W-1:0]  size_q;
    logic [`RIX_FB_SIZE_W-1:0]  pix_idx;
    logic                       last_word_q;
    logic                       pix_take;

    // Stop taking pixels once the final word of the frame is in flight
    assign pix_ready = busy && !last_word_q && (!wr_valid || wr_ready);
    assign pix_take  = pix_ready && pix_valid;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy                 <= 1'b0;
            frame_done           <= 1'b0;
            wr_valid             <= 1'b0;
            last_word_q          <= 1'b0;
            pix_idx              <= '0;
            swap_fb_enable_vsync <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (wr_valid && wr_ready)
            begin
                wr_valid <= 1'b0;
                if (last_word_q)
                begin
                    last_word_q <= 1'b0;
                    busy        <= 1'b0;
                    frame_done  <= 1'b1;
                end
            end
            if (pix_take)
            begin
                wr_valid <= 1'b1;
                pix_idx  <= pix_idx + 1'b1;
                if (pix_idx == size_q - 1'b1)
                    last_word_q <= 1'b1;
            end
            // Commits during a running frame are dropped
            if (commit && !busy)
            begin
                swap_fb_enable_vsync <= cfg.vsync;
                pix_idx              <= '0;
                if (cfg.size == '0)
                    frame_done <= 1'b1;
                else
                    busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (commit && !busy)
        begin
            base_q <= cfg.base;
            size_q <= cfg.size;
        end
        if (pix_take)
        begin
            wr.addr <= base_q + `RIX_ADDR_W'(pix_idx) * `RIX_WORD_BYTES;
            wr.data <= pix_in.data;
        end
    end

endmodule

/* hw/fb_regs.sv */
// **************************************************************************
// Framebuffer register block
// APB slave with frame base, frame size, control and status registers.
// Generates the commit pulse and keeps the sticky done flag behind irq
// **************************************************************************
`include "rix_consts.svh"

module fb_regs
(
    input  logic                aclk,
    input  logic                rst_n,
    input  rix_pkg::apb_req_t   apb_req,
    output rix_pkg::apb_rsp_t   apb_rsp,
    input  logic                busy,
    input  logic                frame_done,
    output rix_pkg::fb_cfg_t    cfg,
    output logic                commit,
    output logic                irq
);
    logic                       access;
    logic                       wr_en;
    logic                       done;
    logic [`RIX_DATA_W-1:0]     rd_data;

    // The access phase is the second cycle of every APB transfer
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg    <= '0;
            commit <= 1'b0;
            done   <= 1'b0;
        end
        else
        begin
            commit <= 1'b0;
            if (wr_en)
            begin
                case (apb_req.paddr)
                    `RIX_REG_FB_BASE: cfg.base <= apb_req.pwdata;
                    `RIX_REG_FB_SIZE: cfg.size <= apb_req.pwdata[`RIX_FB_SIZE_W-1:0];
                    `RIX_REG_CTRL:
                    begin
                        cfg.vsync <= apb_req.pwdata[`RIX_CTRL_VSYNC_BIT];
                        commit    <= apb_req.pwdata[`RIX_CTRL_COMMIT_BIT];
                    end
                    `RIX_REG_STATUS:
                    begin
                        if (apb_req.pwdata[`RIX_STATUS_DONE_BIT])
                            done <= 1'b0;
                    end
                    default: ;
                endcase
            end
            // A finished frame wins over a clear in the same cycle
            if (frame_done)
                done <= 1'b1;
        end
    end

    always_comb
    begin
        rd_data = '0;
        case (apb_req.paddr)
            `RIX_REG_FB_BASE: rd_data = cfg.base;
            `RIX_REG_FB_SIZE: rd_data[`RIX_FB_SIZE_W-1:0] = cfg.size;
            `RIX_REG_CTRL:    rd_data[`RIX_CTRL_VSYNC_BIT] = cfg.vsync;
            `RIX_REG_STATUS:
            begin
                rd_data[`RIX_STATUS_BUSY_BIT] = busy;
                rd_data[`RIX_STATUS_DONE_BIT] = done;
            end
            default: ;
        endcase
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (apb_req.paddr > `RIX_REG_STATUS);

    assign irq = done;

endmodule

/* hw/rix_pkg.sv */
// **************************************************************************
// Rasterizer memory shell types
// Stream beats, memory writes, framebuffer settings and APB transfers
// **************************************************************************
`include "rix_consts.svh"

package rix_pkg;

    // One beat of a valid/ready word stream
    typedef struct packed {
        logic [`RIX_DATA_W-1:0]     data;
        logic                       last;
    } stream_beat_t;

    // A single-word memory write request
    typedef struct packed {
        logic [`RIX_ADDR_W-1:0]     addr;
        logic [`RIX_DATA_W-1:0]     data;
    } mem_wr_t;

    // Frame settings as programmed by software
    typedef struct packed {
        logic [`RIX_ADDR_W-1:0]     base;
        logic [`RIX_FB_SIZE_W-1:0]  size;
        logic                       vsync;
    } fb_cfg_t;

    typedef struct packed {
        logic [`RIX_APB_ADDR_W-1:0] paddr;
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`RIX_DATA_W-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`RIX_DATA_W-1:0]     prdata;
        logic                       pready;
        logic                       pslverr;
    } apb_rsp_t;

endpackage

/* hw/rix_consts.svh */
// **************************************************************************
// Rasterizer memory shell constants
// Word widths, APB register offsets, control/status bit positions and the
// number of memory write requesters
// **************************************************************************
`ifndef RIX_CONSTS_SVH
`define RIX_CONSTS_SVH

`define RIX_DATA_W          32
`define RIX_ADDR_W          32
`define RIX_FB_SIZE_W       20
`define RIX_APB_ADDR_W      4

`define RIX_REG_FB_BASE     4'h0
`define RIX_REG_FB_SIZE     4'h4
`define RIX_REG_CTRL        4'h8
`define RIX_REG_STATUS      4'hC

`define RIX_CTRL_COMMIT_BIT 0
`define RIX_CTRL_VSYNC_BIT  1
`define RIX_STATUS_BUSY_BIT 0
`define RIX_STATUS_DONE_BIT 1

`define RIX_WORD_BYTES      4
`define RIX_ARB_REQS        2

`endif
